//--- design/rx_dma_pkg.sv
// shared rx dma definitions; the clock scale is the fixed COUNT_SCALE and is not derived from a clock setting
package rx_dma_pkg;

    // interrupt delay multiplier for the clock in use
    localparam int COUNT_SCALE = 4;
    // length of one stream reset in cycles
    localparam int RST_HOLD_CYCLES = 8;

    // apb register map
    localparam logic [3:0] ADDR_CTRL       = 4'h0;
    localparam logic [3:0] ADDR_TIMEOUT    = 4'h4;
    localparam logic [3:0] ADDR_INTR_DELAY = 4'h8;
    localparam logic [3:0] ADDR_STATUS     = 4'hC;

    typedef logic [63:0] stream_word_t;
    typedef logic [63:0] tsf_t;
    // rssi in half dB steps
    typedef logic [10:0] rssi_t;
    typedef logic [7:0]  gpio_t;
    // length in bytes
    typedef logic [15:0] pkt_len_t;
    // number of dma beats incl. the two header beats
    typedef logic [13:0] sym_count_t;
    // microsecond ticks
    typedef logic [12:0] timeout_t;
    typedef logic [14:0] intr_delay_t;

    typedef enum logic [1:0] {
        FRAMED  = 2'd0,
        RAW_FCS = 2'd1,
        RAW_SIG = 2'd2,
        RAW_EXT = 2'd3
    } start_mode_t;

    typedef enum logic [2:0] {
        IDLE,
        HDR0,
        HDR1,
        WAIT_FLAG,
        WAIT_TLAST,
        RESETTING
    } framer_state_t;

endpackage

//--- design/rx_stream_if.sv
// one 64-bit stream source toward the arbiter; a beat moves on every valid cycle since there is no ready
`timescale 1ns/100ps

interface rx_stream_if;
    import rx_dma_pkg::*;

    stream_word_t data;
    logic         valid;
    // one cycle pulse that opens a dma transfer
    logic         start;
    // output tlast returned to the source holding the grant
    logic         last_seen;

    modport source (
        output data,
        output valid,
        output start,
        input  last_seen
    );

    modport arbiter (
        input  data,
        input  valid,
        input  start,
        output last_seen
    );

endinterface

//--- design/rx_dma_regs.sv
// apb slave with zero wait states; pslverr on unmapped addresses and on status writes
`timescale 1ns/100ps

module rx_dma_regs (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [3:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  rx_dma_pkg::sym_count_t   sym_count,
    output rx_dma_pkg::start_mode_t  mode,
    output logic                     recover_en,
    output rx_dma_pkg::timeout_t     timeout_top,
    output rx_dma_pkg::intr_delay_t  intr_delay
);
    import rx_dma_pkg::*;

    logic access;
    logic addr_ok;

    assign access = psel && penable;
    assign pready = 1'b1;

    // read mux, also flags unmapped addresses
    always_comb begin
        prdata  = '0;
        addr_ok = 1'b1;
        case (paddr)
            ADDR_CTRL:       prdata = {29'd0, recover_en, mode};
            ADDR_TIMEOUT:    prdata = 32'(timeout_top);
            ADDR_INTR_DELAY: prdata = 32'(intr_delay);
            ADDR_STATUS:     prdata = 32'(sym_count);
            default:         addr_ok = 1'b0;
        endcase
    end

    assign pslverr = access && (!addr_ok || (pwrite && paddr == ADDR_STATUS));

    // writes land in the access phase
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mode        <= FRAMED;
            recover_en  <= 1'b0;
            timeout_top <= '0;
            intr_delay  <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                ADDR_CTRL: begin
                    mode       <= start_mode_t'(pwdata[1:0]);
                    recover_en <= pwdata[2];
                end
                ADDR_TIMEOUT: begin
                    timeout_top <= pwdata[$bits(timeout_t)-1:0];
                end
                ADDR_INTR_DELAY: begin
                    intr_delay <= pwdata[$bits(intr_delay_t)-1:0];
                end
                default: begin
                    mode <= mode;
                end
            endcase
        end
    end

    // the access phase must be preceded by a selected setup phase
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(penable) |-> psel && $past(psel)
    );

endmodule

//--- design/rx_pkt_framer.sv
// header insertion and pass-through for one packet at a time; payload is delayed one cycle, no back-pressure
`timescale 1ns/100ps

module rx_pkt_framer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     sig_valid,
    input  logic                     ht_unsupport,
    input  logic                     ht_aggr,
    input  logic                     ht_aggr_last,
    input  logic                     ht_sgi,
    input  logic [7:0]               pkt_rate,
    input  rx_dma_pkg::pkt_len_t     pkt_len,
    input  rx_dma_pkg::rssi_t        rssi,
    input  rx_dma_pkg::gpio_t        gpio,
    input  rx_dma_pkg::tsf_t         tsf,
    input  rx_dma_pkg::stream_word_t acc_data,
    input  logic                     acc_valid,
    input  logic                     block_flag,
    input  logic                     block_flag_valid,
    input  logic                     tick_1us,
    input  logic                     recover_en,
    input  rx_dma_pkg::timeout_t     timeout_top,
    rx_stream_if.source              src,
    output logic                     stream_rst,
    output logic                     tlast_recover,
    output logic                     sn_incr,
    output rx_dma_pkg::sym_count_t   sym_count,
    output logic                     idle
);
    import rx_dma_pkg::*;

    framer_state_t state;
    tsf_t          tsf_lock;
    stream_word_t  hdr1_word;
    stream_word_t  data_q;
    logic          valid_q;
    logic          start_q;
    timeout_t      timer;
    logic [$clog2(RST_HOLD_CYCLES)-1:0] rst_count;
    logic          accept;
    logic          timed_out;
    logic          flag_allow;
    logic          flag_block;

    assign accept     = (state == IDLE) && sig_valid && !ht_unsupport;
    assign timed_out  = recover_en && (timer > timeout_top);
    assign flag_allow = block_flag_valid && !block_flag;
    assign flag_block = block_flag_valid && block_flag;

    assign sn_incr = (state == WAIT_FLAG) && flag_allow;
    assign idle    = (state == IDLE);

    assign src.data  = data_q;
    assign src.valid = valid_q;
    assign src.start = start_q;

    // header fields captured with the signal field
    always_ff @(posedge clk) begin
        if (accept) begin
            tsf_lock  <= tsf;
            // 0x01 byte marks a packet present in the dma buffer
            hdr1_word <= {8'd0, ht_aggr_last, ht_aggr, ht_sgi, pkt_rate[7], pkt_rate[3:0],
                          pkt_len, 8'h01, gpio, 5'd0, rssi};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= IDLE;
            data_q        <= '0;
            valid_q       <= 1'b0;
            start_q       <= 1'b0;
            stream_rst    <= 1'b0;
            tlast_recover <= 1'b0;
            sym_count     <= '0;
            timer         <= '0;
            rst_count     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    data_q        <= '0;
                    valid_q       <= 1'b0;
                    start_q       <= 1'b0;
                    stream_rst    <= 1'b0;
                    tlast_recover <= 1'b0;
                    timer         <= '0;
                    rst_count     <= '0;
                    if (accept) begin
                        // bytes to 64-bit beats, plus two header beats
                        sym_count <= sym_count_t'(pkt_len[15:3]) + sym_count_t'(|pkt_len[2:0])
                                     + sym_count_t'(2);
                        state     <= HDR0;
                    end
                end
                HDR0: begin
                    data_q  <= tsf_lock;
                    valid_q <= 1'b1;
                    state   <= HDR1;
                end
                HDR1: begin
                    data_q  <= hdr1_word;
                    valid_q <= 1'b1;
                    state   <= WAIT_FLAG;
                end
                WAIT_FLAG: begin
                    data_q  <= acc_data;
                    valid_q <= acc_valid;
                    if (timed_out) begin
                        // fake tlast releases the host dma
                        stream_rst    <= 1'b1;
                        tlast_recover <= 1'b1;
                        state         <= RESETTING;
                    end else if (flag_allow) begin
                        timer   <= '0;
                        start_q <= 1'b1;
                        state   <= WAIT_TLAST;
                    end else if (flag_block) begin
                        stream_rst <= 1'b1;
                        state      <= RESETTING;
                    end else begin
                        timer <= timer + timeout_t'(tick_1us);
                    end
                end
                WAIT_TLAST: begin
                    data_q  <= acc_data;
                    valid_q <= acc_valid;
                    start_q <= 1'b0;
                    if (timed_out) begin
                        stream_rst    <= 1'b1;
                        tlast_recover <= 1'b1;
                        state         <= RESETTING;
                    end else begin
                        timer <= timer + timeout_t'(tick_1us);
                        if (src.last_seen) begin
                            state <= IDLE;
                        end
                    end
                end
                RESETTING: begin
                    data_q        <= '0;
                    valid_q       <= 1'b0;
                    tlast_recover <= 1'b0;
                    sym_count     <= '0;
                    rst_count     <= rst_count + 1'b1;
                    if (rst_count == ($clog2(RST_HOLD_CYCLES))'(RST_HOLD_CYCLES - 1)) begin
                        stream_rst <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    start_one_cycle: assert property (
        @(posedge clk) disable iff (!rstn)
        src.start |=> !src.start
    );

    // a transfer never opens while the stream is held in reset
    start_not_in_reset: assert property (
        @(posedge clk) disable iff (!rstn)
        !(stream_rst && src.start)
    );

endmodule

//--- design/rx_intr_delay.sv
// delayed packet interrupt; the delay setting must be stable two cycles before the dma completion edge
`timescale 1ns/100ps

module rx_intr_delay (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    s2mm_intr,
    input  rx_dma_pkg::intr_delay_t intr_delay,
    output logic                    rx_pkt_intr
);
    import rx_dma_pkg::*;

    // two extra bits hold the COUNT_SCALE product
    logic [$bits(intr_delay_t)+1:0] target;
    logic [$bits(intr_delay_t)+1:0] target_plus1;
    logic [$bits(intr_delay_t)+1:0] count;
    logic                           s2mm_intr_q;
    logic                           armed;
    logic                           intr_edge;

    assign intr_edge = s2mm_intr && !s2mm_intr_q;

    // scaled target in two register stages
    always_ff @(posedge clk) begin
        target       <= ($bits(target))'(intr_delay) * ($bits(target))'(COUNT_SCALE);
        target_plus1 <= target + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2mm_intr_q <= 1'b0;
            armed       <= 1'b0;
            count       <= '0;
            rx_pkt_intr <= 1'b0;
        end else begin
            s2mm_intr_q <= s2mm_intr;
            if (intr_edge) begin
                armed       <= 1'b1;
                count       <= '0;
                rx_pkt_intr <= 1'b0;
            end else begin
                // stop one past the target so the pulse fires once
                if (count != target_plus1) begin
                    count <= count + 1'b1;
                end
                rx_pkt_intr <= armed && (count == target);
            end
        end
    end

endmodule

//--- design/rx_stream_arbiter.sv
// shares the output stream between framer and raw iq; mode changes wait until the framer is idle
`timescale 1ns/100ps

module rx_stream_arbiter (
    input  logic                     clk,
    input  logic                     rstn,
    input  rx_dma_pkg::start_mode_t  mode,
    rx_stream_if.arbiter             framer,
    input  rx_dma_pkg::stream_word_t raw_data,
    input  logic                     raw_valid,
    input  logic                     fcs_valid,
    input  logic                     sig_valid,
    input  logic                     ext_trigger,
    input  logic                     tlast,
    input  logic                     framer_idle,
    output rx_dma_pkg::stream_word_t out_data,
    output logic                     out_valid,
    output logic                     out_start
);
    import rx_dma_pkg::*;

    start_mode_t active_mode;
    logic        raw_grant;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            active_mode <= FRAMED;
        end else if (framer_idle) begin
            active_mode <= mode;
        end
    end

    assign raw_grant = (active_mode != FRAMED);

    assign out_data  = raw_grant ? raw_data : framer.data;
    assign out_valid = raw_grant ? raw_valid : framer.valid;
    // framer only sees tlast for its own transfers
    assign framer.last_seen = !raw_grant && tlast;

    always_comb begin
        case (active_mode)
            FRAMED:  out_start = framer.start;
            RAW_FCS: out_start = fcs_valid;
            RAW_SIG: out_start = sig_valid;
            RAW_EXT: out_start = ext_trigger;
            default: out_start = 1'b0;
        endcase
    end

    // grant settled before the framer leaves idle, and held until it returns
    grant_held_while_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        !framer_idle |-> $stable(raw_grant)
    );

endmodule

//--- design/rx_dma_top.sv
// rx dma framer top; no tready on the output stream, the host block flag and tlast act as the handshake
`timescale 1ns/100ps

module rx_dma_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [3:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     sig_valid,
    input  logic                     ht_unsupport,
    input  logic                     ht_aggr,
    input  logic                     ht_aggr_last,
    input  logic                     ht_sgi,
    input  logic [7:0]               pkt_rate,
    input  rx_dma_pkg::pkt_len_t     pkt_len,
    input  rx_dma_pkg::rssi_t        rssi,
    input  rx_dma_pkg::gpio_t        gpio,
    input  rx_dma_pkg::tsf_t         tsf,
    input  rx_dma_pkg::stream_word_t acc_data,
    input  logic                     acc_valid,
    input  logic                     fcs_valid,
    input  rx_dma_pkg::stream_word_t raw_iq,
    input  logic                     raw_iq_valid,
    input  logic                     ext_trigger,
    input  logic                     tick_1us,
    input  logic                     block_flag,
    input  logic                     block_flag_valid,
    input  logic                     m_axis_tlast,
    input  logic                     s2mm_intr,
    output rx_dma_pkg::stream_word_t m_axis_data,
    output logic                     m_axis_valid,
    output logic                     m_axis_start,
    output logic                     stream_rst,
    output logic                     tlast_recover,
    output logic                     sn_incr,
    output logic                     rx_pkt_intr
);
    import rx_dma_pkg::*;

    start_mode_t mode;
    logic        recover_en;
    timeout_t    timeout_top;
    intr_delay_t intr_delay;
    sym_count_t  sym_count;
    logic        framer_idle;

    rx_stream_if framer_stream ();

    rx_dma_regs u_regs (
        .clk, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .sym_count, .mode, .recover_en, .timeout_top, .intr_delay
    );

    rx_pkt_framer u_framer (
        .clk, .rstn, .sig_valid, .ht_unsupport, .ht_aggr, .ht_aggr_last, .ht_sgi,
        .pkt_rate, .pkt_len, .rssi, .gpio, .tsf, .acc_data, .acc_valid,
        .block_flag, .block_flag_valid, .tick_1us, .recover_en, .timeout_top,
        .src           (framer_stream),
        .stream_rst, .tlast_recover, .sn_incr, .sym_count,
        .idle          (framer_idle)
    );

    rx_intr_delay u_intr_delay (
        .clk, .rstn, .s2mm_intr, .intr_delay, .rx_pkt_intr
    );

    rx_stream_arbiter u_arbiter (
        .clk, .rstn, .mode,
        .framer        (framer_stream),
        .raw_data      (raw_iq),
        .raw_valid     (raw_iq_valid),
        .fcs_valid, .sig_valid, .ext_trigger,
        .tlast         (m_axis_tlast),
        .framer_idle,
        .out_data      (m_axis_data),
        .out_valid     (m_axis_valid),
        .out_start     (m_axis_start)
    );

endmodule

//--- testbench/tb_rx_dma_tasks.svh
// helpers for tb_rx_dma, included in its module body; they use its signals, counters and queue
`ifndef TB_RX_DMA_TASKS_SVH
`define TB_RX_DMA_TASKS_SVH

// second header beat built field by field
function automatic stream_word_t hdr1_ref(input logic aggr_last, input logic aggr,
                                          input logic sgi, input logic [7:0] rate,
                                          input pkt_len_t len, input gpio_t g, input rssi_t r);
    stream_word_t w;
    w = 64'(r);
    w = w | (64'(g) << 16);
    w = w | (64'h01 << 24);
    w = w | (64'(len) << 32);
    w = w | (64'(rate[3:0]) << 48);
    w = w | (64'(rate[7]) << 52);
    w = w | (64'(sgi) << 53);
    w = w | (64'(aggr) << 54);
    w = w | (64'(aggr_last) << 55);
    return w;
endfunction

// payload beats rounded up, plus both header beats
function automatic int sym_count_ref(input int len_bytes);
    return ((len_bytes + 7) / 8 + 2) % (1 << 14);
endfunction

function automatic int intr_cycles_ref(input int delay);
    return delay * 4 + 1;
endfunction

task automatic report_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("ERR %s got %h expected %h", name, got, exp);
    errors++;
endtask

task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
        $display("test %-16s ok", name);
    end else begin
        $display("test %-16s failed with %0d errors", name, errors - err_start);
        tests_failed++;
    end
endtask

task automatic clear_counts();
    start_cnt   = 0;
    sn_cnt      = 0;
    rst_cycles  = 0;
    recover_cnt = 0;
    intr_cnt    = 0;
    tick_cnt    = 0;
endtask

// setup phase, then access phase; response sampled mid access
task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1)
        report_mismatch("pready", pready, 1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] rd;
    apb_access(1'b1, addr, data, rd, err);
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
endtask

task automatic write_readback(input logic [3:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_write(addr, wdata, err);
    if (err !== 1'b0)
        report_mismatch("pslverr", err, 0);
    apb_read(addr, rd, err);
    if (rd !== exp)
        report_mismatch("prdata", rd, exp);
endtask

// signal field with random rate, flags, rssi and gpio; queues both header beats
task automatic send_sig(input pkt_len_t len);
    tsf_t       ts;
    logic [7:0] rate;
    rssi_t      r;
    gpio_t      g;
    logic [2:0] ht;
    ts   = {$random(seed), $random(seed)};
    rate = 8'($random(seed));
    r    = rssi_t'($random(seed));
    g    = gpio_t'($random(seed));
    ht   = 3'($random(seed));
    @(posedge clk);
    sig_valid    <= 1'b1;
    ht_aggr_last <= ht[2];
    ht_aggr      <= ht[1];
    ht_sgi       <= ht[0];
    pkt_rate     <= rate;
    pkt_len      <= len;
    rssi         <= r;
    gpio         <= g;
    tsf          <= ts;
    exp_q.push_back(ts);
    exp_q.push_back(hdr1_ref(ht[2], ht[1], ht[0], rate, len, g, r));
    @(posedge clk);
    sig_valid <= 1'b0;
endtask

task automatic send_payload(input int n);
    stream_word_t w;
    for (int i = 0; i < n; i++) begin
        w = {$random(seed), $random(seed)};
        @(posedge clk);
        acc_data  <= w;
        acc_valid <= 1'b1;
        exp_q.push_back(w);
    end
    @(posedge clk);
    acc_valid <= 1'b0;
endtask

task automatic send_flag(input logic blocked);
    @(posedge clk);
    block_flag_valid <= 1'b1;
    block_flag       <= blocked;
    @(posedge clk);
    block_flag_valid <= 1'b0;
    block_flag       <= 1'b0;
endtask

task automatic send_tlast();
    @(posedge clk);
    m_axis_tlast <= 1'b1;
    @(posedge clk);
    m_axis_tlast <= 1'b0;
endtask

// #1 keeps the queue check clear of the compare process
task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (exp_q.size() != 0) begin
        $display("timed out waiting for %0d expected output beats", exp_q.size());
        errors++;
        exp_q.delete();
    end
endtask

task automatic wait_rst_done(input int max_cycles);
    int n;
    n = 0;
    while ((rst_cycles == 0 || stream_rst) && n < max_cycles) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (rst_cycles == 0 || stream_rst) begin
        $display("timed out waiting for the stream reset to finish");
        errors++;
    end
endtask

`endif

//--- testbench/tb_rx_dma.sv
// testbench for rx_dma_top; no back-pressure, every valid output beat is checked against a queue
`timescale 1ns/100ps

module tb_rx_dma;
    import rx_dma_pkg::*;

    localparam int N_PKTS = 6;
    // about 60 cycles per framed packet plus the other tests
    localparam int TEST_CYCLES = N_PKTS * 60 + 600;

    logic         clk = 1'b0;
    logic         rstn = 1'b0;
    logic         psel = 1'b0;
    logic         penable = 1'b0;
    logic         pwrite = 1'b0;
    logic [3:0]   paddr = '0;
    logic [31:0]  pwdata = '0;
    logic         sig_valid = 1'b0;
    logic         ht_unsupport = 1'b0;
    logic         ht_aggr = 1'b0;
    logic         ht_aggr_last = 1'b0;
    logic         ht_sgi = 1'b0;
    logic [7:0]   pkt_rate = '0;
    pkt_len_t     pkt_len = '0;
    rssi_t        rssi = '0;
    gpio_t        gpio = '0;
    tsf_t         tsf = '0;
    stream_word_t acc_data = '0;
    logic         acc_valid = 1'b0;
    logic         fcs_valid = 1'b0;
    stream_word_t raw_iq = '0;
    logic         raw_iq_valid = 1'b0;
    logic         ext_trigger = 1'b0;
    logic         tick_1us = 1'b0;
    logic         block_flag = 1'b0;
    logic         block_flag_valid = 1'b0;
    logic         m_axis_tlast = 1'b0;
    logic         s2mm_intr = 1'b0;

    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;
    stream_word_t m_axis_data;
    logic         m_axis_valid;
    logic         m_axis_start;
    logic         stream_rst;
    logic         tlast_recover;
    logic         sn_incr;
    logic         rx_pkt_intr;

    int           seed = 44;
    int           errors = 0;
    int           tests_failed = 0;
    stream_word_t exp_q[$];
    stream_word_t exp_word;
    int           start_cnt = 0;
    int           sn_cnt = 0;
    int           rst_cycles = 0;
    int           recover_cnt = 0;
    int           intr_cnt = 0;
    int           tick_cnt = 0;

    `include "tb_rx_dma_tasks.svh"

    always #4 clk = ~clk;

    rx_dma_top DUT (.*);

    // compare every valid beat in order
    always @(negedge clk) begin
        if (rstn && m_axis_valid) begin
            if (exp_q.size() == 0) begin
                $display("output beat %h arrived with none expected", m_axis_data);
                errors++;
            end else begin
                exp_word = exp_q.pop_front();
                if (m_axis_data !== exp_word)
                    report_mismatch("m_axis_data", m_axis_data, exp_word);
            end
        end
    end

    // pulse and cycle counters, ticks only until the first recovery
    always @(negedge clk) begin
        if (rstn) begin
            start_cnt   += int'(m_axis_start);
            sn_cnt      += int'(sn_incr);
            rst_cycles  += int'(stream_rst);
            recover_cnt += int'(tlast_recover);
            intr_cnt    += int'(rx_pkt_intr);
            if (recover_cnt == 0)
                tick_cnt += int'(tick_1us);
        end
    end

    initial begin
        #(TEST_CYCLES * 4 * 8);
        $display("watchdog timed out after %0d ns, the run did not finish", TEST_CYCLES * 32);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic test_apb();
        int          err_start;
        logic [31:0] rd;
        logic        err;
        err_start = errors;
        write_readback(ADDR_CTRL, 32'hffff_fff4, 32'h4);
        write_readback(ADDR_TIMEOUT, 32'hffff_fabc, 32'h1abc);
        write_readback(ADDR_INTR_DELAY, 32'hffff_5a5a, 32'h5a5a);
        apb_read(4'h2, rd, err);
        if (err !== 1'b1)
            report_mismatch("pslverr", err, 1);
        apb_write(ADDR_STATUS, 32'h1, err);
        if (err !== 1'b1)
            report_mismatch("pslverr", err, 1);
        apb_read(ADDR_STATUS, rd, err);
        if (err !== 1'b0)
            report_mismatch("pslverr", err, 0);
        write_readback(ADDR_CTRL, 32'h0, 32'h0);
        write_readback(ADDR_TIMEOUT, 32'h0, 32'h0);
        finish_test("apb registers", err_start);
    endtask

    task automatic test_framed();
        int          err_start;
        int          len;
        logic [31:0] rd;
        logic        err;
        err_start = errors;
        for (int p = 0; p < N_PKTS; p++) begin
            len = 1 + ($unsigned($random(seed)) % 200);
            send_sig(pkt_len_t'(len));
            wait_drain(20);
            apb_read(ADDR_STATUS, rd, err);
            if (rd !== 32'(sym_count_ref(len)))
                report_mismatch("prdata", rd, sym_count_ref(len));
            send_payload(sym_count_ref(len) - 2);
            send_flag(1'b0);
            send_tlast();
            wait_drain(20);
        end
        finish_test("framed packets", err_start);
    endtask

    task automatic test_allow();
        int err_start;
        int len;
        err_start = errors;
        len = 1 + ($unsigned($random(seed)) % 64);
        send_sig(pkt_len_t'(len));
        wait_drain(20);
        clear_counts();
        send_payload(sym_count_ref(len) - 2);
        send_flag(1'b0);
        send_tlast();
        repeat (3) @(posedge clk);
        if (start_cnt != 1)
            report_mismatch("m_axis_start pulses", start_cnt, 1);
        if (sn_cnt != 1)
            report_mismatch("sn_incr pulses", sn_cnt, 1);
        // headers of the next packet show that it was taken
        send_sig(pkt_len_t'(8));
        wait_drain(20);
        send_payload(1);
        send_flag(1'b0);
        send_tlast();
        wait_drain(20);
        finish_test("allowed flag", err_start);
    endtask

    task automatic test_block();
        int          err_start;
        logic [31:0] rd;
        logic        err;
        err_start = errors;
        send_sig(pkt_len_t'(1 + ($unsigned($random(seed)) % 200)));
        wait_drain(20);
        clear_counts();
        send_flag(1'b1);
        wait_rst_done(40);
        repeat (2) @(posedge clk);
        if (rst_cycles != 8)
            report_mismatch("stream_rst cycles", rst_cycles, 8);
        if (start_cnt != 0)
            report_mismatch("m_axis_start pulses", start_cnt, 0);
        if (sn_cnt != 0)
            report_mismatch("sn_incr pulses", sn_cnt, 0);
        apb_read(ADDR_STATUS, rd, err);
        if (rd !== 32'h0)
            report_mismatch("prdata", rd, 0);
        finish_test("blocked flag", err_start);
    endtask

    task automatic test_timeout();
        int   err_start;
        logic err;
        err_start = errors;
        apb_write(ADDR_TIMEOUT, 32'd5, err);
        apb_write(ADDR_CTRL, 32'h4, err);
        send_sig(pkt_len_t'(16));
        wait_drain(20);
        clear_counts();
        @(posedge clk);
        tick_1us <= 1'b1;
        wait_rst_done(100);
        @(posedge clk);
        tick_1us <= 1'b0;
        if (recover_cnt != 1)
            report_mismatch("tlast_recover pulses", recover_cnt, 1);
        if (tick_cnt <= 5) begin
            $display("tlast_recover came after only %0d ticks", tick_cnt);
            errors++;
        end
        if (rst_cycles != 8)
            report_mismatch("stream_rst cycles", rst_cycles, 8);
        // recovery off: no pulse however long the ticks run
        apb_write(ADDR_CTRL, 32'h0, err);
        send_sig(pkt_len_t'(16));
        wait_drain(20);
        clear_counts();
        @(posedge clk);
        tick_1us <= 1'b1;
        repeat (40) @(posedge clk);
        tick_1us <= 1'b0;
        if (recover_cnt != 0)
            report_mismatch("tlast_recover pulses", recover_cnt, 0);
        if (rst_cycles != 0)
            report_mismatch("stream_rst cycles", rst_cycles, 0);
        send_flag(1'b0);
        send_tlast();
        finish_test("timeout recovery", err_start);
    endtask

    task automatic test_intr_raw();
        int           err_start;
        int           delay;
        int           n;
        logic         err;
        stream_word_t w;
        err_start = errors;
        delay = 2 + ($unsigned($random(seed)) % 10);
        apb_write(ADDR_INTR_DELAY, 32'(delay), err);
        repeat (4) @(posedge clk);
        clear_counts();
        @(posedge clk);
        s2mm_intr <= 1'b1;
        // count from the edge that samples s2mm_intr high
        @(posedge clk);
        @(negedge clk);
        n = 0;
        while (!rx_pkt_intr && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!rx_pkt_intr) begin
            $display("rx_pkt_intr never rose within 200 cycles");
            errors++;
        end else if (n != intr_cycles_ref(delay)) begin
            report_mismatch("rx_pkt_intr delay cycles", n, intr_cycles_ref(delay));
        end
        @(posedge clk);
        s2mm_intr <= 1'b0;
        repeat (20) @(posedge clk);
        if (intr_cnt != 1)
            report_mismatch("rx_pkt_intr pulses", intr_cnt, 1);
        // raw loopback with the external trigger as start
        apb_write(ADDR_CTRL, 32'(RAW_EXT), err);
        repeat (3) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            w = {$random(seed), $random(seed)};
            @(posedge clk);
            raw_iq       <= w;
            raw_iq_valid <= 1'b1;
            ext_trigger  <= (i == 2 || i == 5);
            exp_q.push_back(w);
            @(negedge clk);
            if (m_axis_start !== ext_trigger)
                report_mismatch("m_axis_start", m_axis_start, ext_trigger);
        end
        @(posedge clk);
        raw_iq_valid <= 1'b0;
        ext_trigger  <= 1'b0;
        wait_drain(10);
        apb_write(ADDR_CTRL, 32'h0, err);
        repeat (3) @(posedge clk);
        finish_test("intr and raw", err_start);
    endtask

    initial begin
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        test_apb();
        test_framed();
        test_allow();
        test_block();
        test_timeout();
        test_intr_raw();
        repeat (4) @(posedge clk);
        $display("6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rx_dma.f
+incdir+testbench
design/rx_dma_pkg.sv
design/rx_stream_if.sv
design/rx_dma_regs.sv
design/rx_pkt_framer.sv
design/rx_intr_delay.sv
design/rx_stream_arbiter.sv
design/rx_dma_top.sv
testbench/tb_rx_dma.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_rx_dma
RTL_TOP    := rx_dma_top
FILELIST   := rx_dma.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
